// File: all.f
source/uart_rx_pkg.sv
source/rx_frame_decoder.sv
source/rx_fifo.sv
source/apb_rx_regs.sv
source/dual_uart_rx.sv
tests/tb_clock_gen.sv
tests/tb_dual_uart_rx.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f all.f --top-module tb_dual_uart_rx -o tb_sim

out=$(./obj_dir/tb_sim 2>&1 || true)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "Simulation finished: PASS"

// File: source/apb_rx_regs.sv
`timescale 1ns/1ps

module apb_rx_regs
	import uart_rx_pkg::*;
(
	input  logic      baud_rx_clock,
	input  logic      i_rst,
	input  apb_req_t  i_apb,
	output apb_rsp_t  o_apb,
	input  logic      i_empty0,
	input  logic      i_empty1,
	input  rx_frame_t i_head0,
	input  rx_frame_t i_head1,
	input  logic      i_dropped0,
	input  logic      i_dropped1,
	output logic      o_pop0,
	output logic      o_pop1,
	output logic      o_enable0,
	output logic      o_enable1
);

	logic access;
	logic rd_en;
	logic wr_en;

	logic [1:0] ctrl_q;
	logic [1:0] ovf_q;
	logic [1:0] ovf_clr;

	logic [31:0] status_word;
	logic [31:0] data0_word;
	logic [31:0] data1_word;
	logic [31:0] rdata;
	logic slverr;

	assign access = i_apb.psel & i_apb.penable;
	assign rd_en  = access & ~i_apb.pwrite;
	assign wr_en  = access & i_apb.pwrite;

	assign status_word = {22'b0, ovf_q, 6'b0, ~i_empty1, ~i_empty0};

	// Bit 31 marks a valid frame
	assign data0_word = {1'b1, 22'b0, i_head0.framing_err, i_head0.data};
	assign data1_word = {1'b1, 22'b0, i_head1.framing_err, i_head1.data};

	always_comb begin
		rdata  = 32'b0;
		slverr = 1'b0;
		case (i_apb.paddr)
			ADDR_STATUS: begin
				rdata = status_word;
			end
			ADDR_CTRL: begin
				rdata = {30'b0, ctrl_q};
			end
			ADDR_DATA0: begin
				if (i_empty0) begin
					slverr = ~i_apb.pwrite;
				end else begin
					rdata = data0_word;
				end
			end
			ADDR_DATA1: begin
				if (i_empty1) begin
					slverr = ~i_apb.pwrite;
				end else begin
					rdata = data1_word;
				end
			end
			default: begin
				slverr = 1'b1;
			end
		endcase
	end

	// Zero wait states
	assign o_apb.pready  = 1'b1;
	assign o_apb.prdata  = rd_en ? rdata : 32'b0;
	assign o_apb.pslverr = access & slverr;

	// Pop only when the read actually hands out a frame
	assign o_pop0 = rd_en & (i_apb.paddr == ADDR_DATA0) & ~i_empty0;
	assign o_pop1 = rd_en & (i_apb.paddr == ADDR_DATA1) & ~i_empty1;

	assign ovf_clr = (wr_en && i_apb.paddr == ADDR_STATUS) ? i_apb.pwdata[9:8] : 2'b00;

	always_ff @(posedge baud_rx_clock) begin
		if (i_rst) begin
			ctrl_q <= 2'b11;
			ovf_q  <= 2'b00;
		end else begin
			if (wr_en && i_apb.paddr == ADDR_CTRL) begin
				ctrl_q <= i_apb.pwdata[1:0];
			end
			// A new drop beats a clear in the same cycle
			ovf_q <= (ovf_q & ~ovf_clr) | {i_dropped1, i_dropped0};
		end
	end

	assign o_enable0 = ctrl_q[0];
	assign o_enable1 = ctrl_q[1];

endmodule

// File: source/dual_uart_rx.sv
`timescale 1ns/1ps

module dual_uart_rx
	import uart_rx_pkg::*;
(
	input  logic     baud_rx_clock,
	input  logic     i_rst,
	input  logic     i_rx0,
	input  logic     i_rx1,
	input  apb_req_t i_apb,
	output apb_rsp_t o_apb
);

	logic enable0;
	logic enable1;
	logic push0;
	logic push1;
	rx_frame_t frame0;
	rx_frame_t frame1;
	rx_frame_t head0;
	rx_frame_t head1;
	logic empty0;
	logic empty1;
	logic dropped0;
	logic dropped1;
	logic pop0;
	logic pop1;

	// Channel 0
	rx_frame_decoder u_dec0 (
		.baud_rx_clock (baud_rx_clock),
		.i_rst         (i_rst),
		.i_enable      (enable0),
		.i_rx          (i_rx0),
		.o_push        (push0),
		.o_frame       (frame0)
	);

	rx_fifo u_fifo0 (
		.baud_rx_clock (baud_rx_clock),
		.i_rst         (i_rst),
		.i_push        (push0),
		.i_frame       (frame0),
		.i_pop         (pop0),
		.o_head        (head0),
		.o_empty       (empty0),
		.o_dropped     (dropped0)
	);

	// Channel 1
	rx_frame_decoder u_dec1 (
		.baud_rx_clock (baud_rx_clock),
		.i_rst         (i_rst),
		.i_enable      (enable1),
		.i_rx          (i_rx1),
		.o_push        (push1),
		.o_frame       (frame1)
	);

	rx_fifo u_fifo1 (
		.baud_rx_clock (baud_rx_clock),
		.i_rst         (i_rst),
		.i_push        (push1),
		.i_frame       (frame1),
		.i_pop         (pop1),
		.o_head        (head1),
		.o_empty       (empty1),
		.o_dropped     (dropped1)
	);

	apb_rx_regs u_regs (
		.baud_rx_clock (baud_rx_clock),
		.i_rst         (i_rst),
		.i_apb         (i_apb),
		.o_apb         (o_apb),
		.i_empty0      (empty0),
		.i_empty1      (empty1),
		.i_head0       (head0),
		.i_head1       (head1),
		.i_dropped0    (dropped0),
		.i_dropped1    (dropped1),
		.o_pop0        (pop0),
		.o_pop1        (pop1),
		.o_enable0     (enable0),
		.o_enable1     (enable1)
	);

endmodule

// File: source/rx_fifo.sv
`timescale 1ns/1ps

module rx_fifo
	import uart_rx_pkg::*;
(
	input  logic      baud_rx_clock,
	input  logic      i_rst,
	input  logic      i_push,
	input  rx_frame_t i_frame,
	input  logic      i_pop,
	output rx_frame_t o_head,
	output logic      o_empty,
	output logic      o_dropped
);

	rx_frame_t mem [FIFO_DEPTH];

	logic [FIFO_ADDR_W-1:0] wr_ptr;
	logic [FIFO_ADDR_W-1:0] rd_ptr;
	logic [FIFO_ADDR_W:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full    = (count == (FIFO_ADDR_W + 1)'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign do_push = i_push & ~full;
	assign do_pop  = i_pop & ~o_empty;

	// A push into a full FIFO is lost, flagged in the same cycle
	assign o_dropped = i_push & full;

	// Show-ahead head
	assign o_head = mem[rd_ptr];

	always_ff @(posedge baud_rx_clock) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge baud_rx_clock) begin
		if (do_push) begin
			mem[wr_ptr] <= i_frame;
		end
	end

endmodule

// File: source/rx_frame_decoder.sv
`timescale 1ns/1ps

module rx_frame_decoder
	import uart_rx_pkg::*;
(
	input  logic      baud_rx_clock,
	input  logic      i_rst,
	input  logic      i_enable,
	input  logic      i_rx,
	output logic      o_push,
	output rx_frame_t o_frame
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP,
		ST_WAIT_HIGH
	} state_t;

	state_t state;

	logic [1:0] rx_sync;
	logic rx_line;
	logic rx_prev;
	logic start_edge;

	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic sample_now;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge baud_rx_clock) begin
		if (i_rst) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], i_rx};
			rx_prev <= rx_sync[1];
		end
	end

	assign rx_line = rx_sync[1];
	assign start_edge = rx_prev & ~rx_line;

	// Start bit is checked half a bit after the edge, every later bit a full period on
	always_comb begin
		if (state == ST_START) begin
			sample_now = (clk_cnt == CNT_W'(HALF_BIT - 1));
		end else begin
			sample_now = (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1));
		end
	end

	always_ff @(posedge baud_rx_clock) begin
		if (i_rst) begin
			state   <= ST_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			o_push  <= 1'b0;
		end else begin
			o_push <= 1'b0;
			if (!i_enable) begin
				state   <= ST_IDLE;
				clk_cnt <= '0;
			end else begin
				case (state)
					ST_IDLE: begin
						if (start_edge) begin
							state   <= ST_START;
							clk_cnt <= '0;
						end
					end
					ST_START: begin
						if (sample_now) begin
							clk_cnt <= '0;
							bit_idx <= '0;
							// Line back high at mid start bit means a glitch
							if (rx_line) begin
								state <= ST_IDLE;
							end else begin
								state <= ST_DATA;
							end
						end else begin
							clk_cnt <= clk_cnt + 1'b1;
						end
					end
					ST_DATA: begin
						if (sample_now) begin
							clk_cnt <= '0;
							if (bit_idx == 3'd7) begin
								state <= ST_STOP;
							end else begin
								bit_idx <= bit_idx + 1'b1;
							end
						end else begin
							clk_cnt <= clk_cnt + 1'b1;
						end
					end
					ST_STOP: begin
						if (sample_now) begin
							clk_cnt <= '0;
							o_push  <= 1'b1;
							if (rx_line) begin
								state <= ST_IDLE;
							end else begin
								state <= ST_WAIT_HIGH;
							end
						end else begin
							clk_cnt <= clk_cnt + 1'b1;
						end
					end
					ST_WAIT_HIGH: begin
						// Hold off until the line is released after a bad stop bit
						if (rx_line) begin
							state <= ST_IDLE;
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge baud_rx_clock) begin
		if (state == ST_DATA && sample_now) begin
			shift <= {rx_line, shift[7:1]};
		end
		if (state == ST_STOP && sample_now) begin
			o_frame.data        <= shift;
			o_frame.framing_err <= ~rx_line;
		end
	end

endmodule

// File: source/uart_rx_pkg.sv
package uart_rx_pkg;

	// Serial timing, counted in baud_rx_clock cycles
	localparam int CLOCKS_PER_BIT = 64;
	localparam int HALF_BIT       = 32;
	localparam int CNT_W          = $clog2(CLOCKS_PER_BIT);

	// Receive FIFO geometry
	localparam int FIFO_DEPTH  = 16;
	localparam int FIFO_ADDR_W = 4;

	// APB register map, byte addresses
	localparam logic [3:0] ADDR_STATUS = 4'h0;
	localparam logic [3:0] ADDR_CTRL   = 4'h4;
	localparam logic [3:0] ADDR_DATA0  = 4'h8;
	localparam logic [3:0] ADDR_DATA1  = 4'hC;

	// One received character plus its stop-bit status
	typedef struct packed {
		logic [7:0] data;
		logic       framing_err;
	} rx_frame_t;

	// Master to slave
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// Slave to master
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	// 4 ns period
	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	initial begin
		o_rst = 1'b1;
		repeat (16) @(posedge o_clk);
		#1;
		o_rst = 1'b0;
	end

endmodule

// File: tests/tb_dual_uart_rx.sv
`timescale 1ns/1ps

module tb_dual_uart_rx
	import uart_rx_pkg::*;
;

	localparam int POLL_LIMIT = 400;

	logic baud_rx_clock;
	logic rst;
	logic rx0;
	logic rx1;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	logic [31:0] lfsr_q = 32'he24f;
	logic [8:0] sent_q0[$];
	logic [8:0] sent_q1[$];

	tb_clock_gen clk_gen0 (
		.o_clk (baud_rx_clock),
		.o_rst (rst)
	);

	dual_uart_rx dut0 (
		.baud_rx_clock (baud_rx_clock),
		.i_rst         (rst),
		.i_rx0         (rx0),
		.i_rx1         (rx1),
		.i_apb         (apb_req),
		.o_apb         (apb_rsp)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end else begin
			return s >> 1;
		end
	endfunction

	// Expected DATAn word for a frame
	function automatic logic [31:0] expected_word(input logic [7:0] data, input logic ferr);
		logic [31:0] w;
		w = 32'h8000_0000;
		w[8] = ferr;
		w[7:0] = data;
		return w;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic tick();
		@(posedge baud_rx_clock);
		#1;
	endtask

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			b[i] = lfsr_q[0];
		end
	endtask

	task automatic set_line(input int ch, input logic v);
		if (ch == 0) begin
			rx0 = v;
		end else begin
			rx1 = v;
		end
	endtask

	task automatic hold_bit();
		repeat (CLOCKS_PER_BIT) tick();
	endtask

	task automatic send_frame(input int ch, input logic [7:0] b, input logic stop_ok,
			input logic record);
		set_line(ch, 1'b0);
		hold_bit();
		for (int i = 0; i < 8; i++) begin
			set_line(ch, b[i]);
			hold_bit();
		end
		set_line(ch, stop_ok);
		hold_bit();
		set_line(ch, 1'b1);
		repeat (16) tick();
		if (record && ch == 0) begin
			sent_q0.push_back({~stop_ok, b});
		end else if (record) begin
			sent_q1.push_back({~stop_ok, b});
		end
	endtask

	// Idle long enough for a wrongly accepted start to finish a whole frame
	task automatic send_glitch(input int ch, input int len);
		set_line(ch, 1'b0);
		repeat (len) tick();
		set_line(ch, 1'b1);
		repeat (12 * CLOCKS_PER_BIT) tick();
	endtask

	// Setup cycle followed by an access cycle sampled just before its closing edge
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		tick();
		apb_req.penable = 1'b1;
		#2;
		check_equal("pready", 32'(apb_rsp.pready), 32'd1);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		tick();
		apb_req = '0;
	endtask

	task automatic expect_read(input logic [3:0] addr, input logic [31:0] exp_data,
			input logic exp_err, input string name);
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, addr, 32'b0, rd, err);
		check_equal(name, rd, exp_data);
		check_equal({name, " pslverr"}, 32'(err), 32'(exp_err));
	endtask

	task automatic expect_write(input logic [3:0] addr, input logic [31:0] data,
			input logic exp_err, input string name);
		logic [31:0] rd;
		logic err;
		apb_access(1'b1, addr, data, rd, err);
		check_equal({name, " pslverr"}, 32'(err), 32'(exp_err));
	endtask

	task automatic wait_not_empty(input int ch);
		logic [31:0] st;
		logic err;
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < POLL_LIMIT && !seen; i++) begin
			apb_access(1'b0, ADDR_STATUS, 32'b0, st, err);
			seen = st[ch];
		end
		if (!seen) begin
			fail_run($sformatf("Timed out waiting for a frame on channel %0d", ch));
		end
	endtask

	// Reads back every recorded frame of one channel in order
	task automatic drain_channel(input int ch);
		logic [8:0] exp;
		logic [3:0] addr;
		int n;
		addr = (ch == 0) ? ADDR_DATA0 : ADDR_DATA1;
		n = (ch == 0) ? sent_q0.size() : sent_q1.size();
		for (int i = 0; i < n; i++) begin
			wait_not_empty(ch);
			if (ch == 0) begin
				exp = sent_q0.pop_front();
			end else begin
				exp = sent_q1.pop_front();
			end
			expect_read(addr, expected_word(exp[7:0], exp[8]), 1'b0, $sformatf("DATA%0d", ch));
		end
	endtask

	initial begin
		logic [7:0] bytes0 [6];
		logic [7:0] bytes1 [6];
		logic [7:0] b;
		rx0 = 1'b1;
		rx1 = 1'b1;
		apb_req = '0;
		for (int i = 0; i < 100 && rst !== 1'b0; i++) begin
			@(posedge baud_rx_clock);
		end
		if (rst !== 1'b0) begin
			fail_run("Reset was never released");
		end
		tick();

		expect_read(ADDR_STATUS, 32'h0, 1'b0, "STATUS");
		expect_read(ADDR_CTRL, 32'h3, 1'b0, "CTRL");
		expect_read(ADDR_DATA0, 32'h0, 1'b1, "DATA0 empty");
		expect_read(ADDR_DATA1, 32'h0, 1'b1, "DATA1 empty");

		// Both lines busy together
		for (int i = 0; i < 6; i++) begin
			random_byte(bytes0[i]);
			random_byte(bytes1[i]);
		end
		fork
			for (int i = 0; i < 6; i++) send_frame(0, bytes0[i], 1'b1, 1'b1);
			for (int i = 0; i < 6; i++) send_frame(1, bytes1[i], 1'b1, 1'b1);
		join
		drain_channel(0);
		drain_channel(1);
		expect_read(ADDR_STATUS, 32'h0, 1'b0, "STATUS");

		random_byte(b);
		send_frame(0, b, 1'b0, 1'b1);
		random_byte(b);
		send_frame(0, b, 1'b1, 1'b1);
		drain_channel(0);
		expect_read(ADDR_STATUS, 32'h0, 1'b0, "STATUS");

		send_glitch(1, 8);
		expect_read(ADDR_STATUS, 32'h0, 1'b0, "STATUS after glitch");
		expect_write(ADDR_CTRL, 32'h2, 1'b0, "CTRL");
		random_byte(bytes0[0]);
		random_byte(bytes1[0]);
		fork
			send_frame(0, bytes0[0], 1'b1, 1'b0);
			send_frame(1, bytes1[0], 1'b1, 1'b1);
		join
		drain_channel(1);
		expect_read(ADDR_STATUS, 32'h0, 1'b0, "STATUS with channel 0 off");
		expect_write(ADDR_CTRL, 32'h3, 1'b0, "CTRL");

		// Seventeenth frame finds the FIFO full
		for (int i = 0; i < 17; i++) begin
			random_byte(b);
			send_frame(0, b, 1'b1, (i < 16));
		end
		expect_read(ADDR_STATUS, 32'h101, 1'b0, "STATUS overflow");
		drain_channel(0);
		expect_read(ADDR_STATUS, 32'h100, 1'b0, "STATUS drained");
		expect_write(ADDR_STATUS, 32'h300, 1'b0, "STATUS");
		expect_read(ADDR_STATUS, 32'h0, 1'b0, "STATUS cleared");

		expect_read(4'h2, 32'h0, 1'b1, "unmapped read");
		expect_write(4'h6, 32'h1, 1'b1, "unmapped write");
		expect_write(ADDR_CTRL, 32'hFFFF_FFFE, 1'b0, "CTRL");
		expect_read(ADDR_CTRL, 32'h2, 1'b0, "CTRL masked");
		expect_write(ADDR_CTRL, 32'h3, 1'b0, "CTRL");
		expect_read(ADDR_CTRL, 32'h3, 1'b0, "CTRL");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
